// ==== logic/cpu_pkg.sv ====
/*
 * cpu shared types: widths, opcodes, instruction word views,
 * host link payloads and pipeline register contents
 */
package cpu_pkg;

    parameter int IMEM_AW_DEFAULT = 8;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    typedef enum logic [7:0] {
        NOP  = 8'h00,
        ADD  = 8'h01,
        SUB  = 8'h02,
        AND  = 8'h03,
        OR   = 8'h04,
        XOR  = 8'h05,
        ADDI = 8'h10,
        OUT  = 8'h11,
        HALT = 8'hff
    } opcode_t;

    //////////////////////////////
    // instruction word views

    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [11:0] unused;
    } instr_r_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs;
        logic [15:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    //////////////////////////////
    // link payloads and pipeline registers

    typedef struct packed {
        logic [7:0] addr;
        word_t      data;
        logic       last;  // final word of the program
    } load_word_t;

    typedef struct packed {
        logic [15:0] addr;
        word_t       data;
    } host_write_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    store_data;  // rd value for OUT
    } dx_t;

    typedef struct packed {
        logic     valid;
        logic     we;
        reg_idx_t rd;
        word_t    result;
    } xw_t;

    function automatic logic is_reg_form(opcode_t op);
        return op inside {ADD, SUB, AND, OR, XOR};
    endfunction

    function automatic logic uses_imm(opcode_t op);
        return op inside {ADDI, OUT};
    endfunction

    function automatic logic writes_rd(opcode_t op);
        return is_reg_form(op) || (op == ADDI);
    endfunction

endpackage

// ==== logic/alu.sv ====
/*
 * integer ALU, operation picked directly from the opcode
 */
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::opcode_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   y
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            ADD, ADDI, OUT: y = a + b;  // OUT computes its host address
            SUB:            y = a - b;
            AND:            y = a & b;
            OR:             y = a | b;
            XOR:            y = a ^ b;
            default:        y = '0;
        endcase
    end

endmodule

// ==== logic/reg_file.sv ====
/*
 * register file, sixteen words with r0 tied to zero,
 * two read ports and a write-through write port
 */
`timescale 1ns/1ns

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t rs_sel,
    input  cpu_pkg::reg_idx_t rt_sel,
    output cpu_pkg::word_t    rs_val,
    output cpu_pkg::word_t    rt_val,
    input  cpu_pkg::xw_t      wr
);
    import cpu_pkg::*;

    word_t regs [16];
    logic  wr_en;

    assign wr_en = wr.valid && wr.we && (wr.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr.rd] <= wr.result;
        end
    end

    // same-cycle write is visible on the read ports
    always_comb begin
        if (rs_sel == '0)
            rs_val = '0;
        else if (wr_en && wr.rd == rs_sel)
            rs_val = wr.result;
        else
            rs_val = regs[rs_sel];

        if (rt_sel == '0)
            rt_val = '0;
        else if (wr_en && wr.rd == rt_sel)
            rt_val = wr.result;
        else
            rt_val = regs[rt_sel];
    end

endmodule

// ==== logic/instr_mem.sv ====
/*
 * instruction memory, written by the boot loader and read by fetch
 * with one cycle of latency
 */
`timescale 1ns/1ns

module instr_mem #(
    parameter int IMEM_AW = cpu_pkg::IMEM_AW_DEFAULT
) (
    input  logic               clk,
    input  logic               we,
    input  logic [IMEM_AW-1:0] addr,
    input  cpu_pkg::word_t     wdata,
    output cpu_pkg::instr_u    rdata
);
    import cpu_pkg::*;

    localparam int DEPTH = 2 ** IMEM_AW;

    word_t mem [DEPTH];

    // registered read, same address gives the same word back
    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= instr_u'(mem[addr]);
    end

endmodule

// ==== logic/exec_stage.sv ====
/*
 * execute stage: decode/execute register with operand select,
 * ALU, and the execute/writeback register
 */
`timescale 1ns/1ns

module exec_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 freeze,
    input  cpu_pkg::instr_u      issue,
    input  cpu_pkg::word_t       rs_val,
    input  cpu_pkg::word_t       rt_val,
    output cpu_pkg::dx_t         dx_pending,
    output cpu_pkg::xw_t         xw_pending,
    output logic                 out_fire,
    output cpu_pkg::host_write_t host_write_in
);
    import cpu_pkg::*;

    dx_t   dx_next;
    xw_t   xw_next;
    word_t alu_y;

    always_comb begin
        dx_next.valid      = (issue.r.opcode != NOP);
        dx_next.opcode     = issue.r.opcode;
        dx_next.rd         = issue.r.rd;
        dx_next.a          = rs_val;
        dx_next.store_data = rt_val;
        if (uses_imm(issue.r.opcode))
            dx_next.b = {{16{issue.i.imm[15]}}, issue.i.imm};  // sign extend
        else
            dx_next.b = rt_val;
    end

    alu u_alu (
        .op (dx_pending.opcode),
        .a  (dx_pending.a),
        .b  (dx_pending.b),
        .y  (alu_y)
    );

    always_comb begin
        xw_next.valid  = dx_pending.valid;
        xw_next.we     = dx_pending.valid && writes_rd(dx_pending.opcode);
        xw_next.rd     = dx_pending.rd;
        xw_next.result = alu_y;
    end

    assign out_fire           = dx_pending.valid && (dx_pending.opcode == OUT);
    assign host_write_in.addr = alu_y[15:0];
    assign host_write_in.data = dx_pending.store_data;

    // both stages hold while the host write is outstanding
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dx_pending <= '0;
            xw_pending <= '0;
        end else if (!freeze) begin
            dx_pending <= dx_next;
            xw_pending <= xw_next;
        end
    end

endmodule

// ==== logic/cpu_sequencer.sv ====
/*
 * cpu control: boot loader, fetch and stall logic,
 * host write-out handshake and halt detection
 */
`timescale 1ns/1ns

module cpu_sequencer #(
    parameter int IMEM_AW = cpu_pkg::IMEM_AW_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_req,
    input  cpu_pkg::load_word_t  load_word,
    output logic                 load_ack,
    output logic                 host_req,
    input  logic                 host_ack,
    output logic                 imem_we,
    output logic [IMEM_AW-1:0]   imem_addr,
    output cpu_pkg::word_t       imem_wdata,
    input  cpu_pkg::instr_u      fetched,
    output cpu_pkg::reg_idx_t    rs_sel,
    output cpu_pkg::reg_idx_t    rt_sel,
    input  cpu_pkg::xw_t         xw_pending,
    input  cpu_pkg::dx_t         dx_pending,
    output logic                 freeze,
    output cpu_pkg::instr_u      issue,
    input  logic                 out_fire,
    input  cpu_pkg::host_write_t host_write_in,
    output cpu_pkg::host_write_t host_write,
    output logic                 halted
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        BOOT,
        RUN,
        HOST_WAIT,
        HOST_RELEASE,
        DRAIN,
        HALTED
    } state_t;

    state_t             state;
    logic [IMEM_AW-1:0] pc;           // next fetch address
    logic               fv;           // fetched word is a real instruction
    logic               halt_seen;
    logic               last_loaded;
    logic               running;
    logic               stall;
    logic               halt_dec;
    opcode_t            dec_op;

    // source register still being produced further down the pipe
    function automatic logic clash(reg_idx_t src, dx_t dx, xw_t xw);
        return (dx.valid && writes_rd(dx.opcode) && dx.rd == src) ||
               (xw.valid && xw.we && xw.rd == src);
    endfunction

    assign running = (state == RUN) || (state == DRAIN);
    assign freeze  = (state == HOST_WAIT) || (state == HOST_RELEASE);
    assign halted  = (state == HALTED);

    //////////////////////////////
    // decode side

    assign dec_op   = fetched.r.opcode;
    assign rs_sel   = fetched.r.rs;
    assign rt_sel   = (dec_op == OUT) ? fetched.i.rd : fetched.r.rt;  // OUT sends rd
    assign halt_dec = fv && (state == RUN) && (dec_op == HALT);

    always_comb begin
        stall = 1'b0;
        if (fv && state == RUN) begin
            if (is_reg_form(dec_op) || uses_imm(dec_op))
                stall = stall | clash(fetched.r.rs, dx_pending, xw_pending);
            if (is_reg_form(dec_op))
                stall = stall | clash(fetched.r.rt, dx_pending, xw_pending);
            if (dec_op == OUT)
                stall = stall | clash(fetched.i.rd, dx_pending, xw_pending);
        end
    end

    always_comb begin
        issue = '0;  // bubble
        if (fv && state == RUN && !stall)
            issue = fetched;
    end

    //////////////////////////////
    // instruction memory port

    assign imem_we    = (state == BOOT) && load_req && !load_ack;
    assign imem_wdata = load_word.data;

    always_comb begin
        if (state == BOOT)
            imem_addr = IMEM_AW'(load_word.addr);
        else if (freeze || stall)
            imem_addr = pc - 1'b1;  // re-read the word in decode
        else
            imem_addr = pc;
    end

    //////////////////////////////
    // control FSM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= BOOT;
            pc          <= '0;
            fv          <= 1'b0;
            halt_seen   <= 1'b0;
            last_loaded <= 1'b0;
            load_ack    <= 1'b0;
            host_req    <= 1'b0;
        end else begin
            case (state)
                BOOT: begin
                    if (imem_we) begin
                        load_ack    <= 1'b1;
                        last_loaded <= load_word.last;
                    end else if (load_ack && !load_req) begin
                        load_ack <= 1'b0;
                        if (last_loaded) begin
                            state <= RUN;
                            pc    <= '0;
                            fv    <= 1'b0;
                        end
                    end
                end
                RUN, DRAIN: begin
                    if (halt_dec) begin
                        fv        <= 1'b0;  // nothing fetched past HALT
                        halt_seen <= 1'b1;
                    end else if (state == RUN && !stall) begin
                        pc <= pc + 1'b1;
                        fv <= 1'b1;
                    end
                    if (out_fire) begin
                        host_req <= 1'b1;
                        state    <= HOST_WAIT;
                    end else if (halt_dec) begin
                        state <= DRAIN;
                    end else if (state == DRAIN && !dx_pending.valid && !xw_pending.valid) begin
                        state <= HALTED;
                    end
                end
                HOST_WAIT: begin
                    if (host_ack) begin
                        host_req <= 1'b0;
                        state    <= HOST_RELEASE;
                    end
                end
                HOST_RELEASE: begin
                    if (!host_ack)
                        state <= halt_seen ? DRAIN : RUN;
                end
                default: ;  // halted until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (running && out_fire)
            host_write <= host_write_in;
    end

endmodule

// ==== logic/cpu_top.sv ====
/*
 * cpu top level, boot link in, host write link out,
 * four stage pipeline underneath
 */
`timescale 1ns/1ns

module cpu_top #(
    parameter int IMEM_AW = cpu_pkg::IMEM_AW_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_req,
    input  cpu_pkg::load_word_t  load_word,
    output logic                 load_ack,
    output logic                 host_req,
    output cpu_pkg::host_write_t host_write,
    input  logic                 host_ack,
    output logic                 halted
);
    import cpu_pkg::*;

    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    word_t              imem_wdata;
    instr_u             fetched;
    reg_idx_t           rs_sel;
    reg_idx_t           rt_sel;
    word_t              rs_val;
    word_t              rt_val;
    dx_t                dx_pending;
    xw_t                xw_pending;
    logic               freeze;
    instr_u             issue;
    logic               out_fire;
    host_write_t        host_write_in;

    cpu_sequencer #(.IMEM_AW(IMEM_AW)) u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_req      (load_req),
        .load_word     (load_word),
        .load_ack      (load_ack),
        .host_req      (host_req),
        .host_ack      (host_ack),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_wdata    (imem_wdata),
        .fetched       (fetched),
        .rs_sel        (rs_sel),
        .rt_sel        (rt_sel),
        .xw_pending    (xw_pending),
        .dx_pending    (dx_pending),
        .freeze        (freeze),
        .issue         (issue),
        .out_fire      (out_fire),
        .host_write_in (host_write_in),
        .host_write    (host_write),
        .halted        (halted)
    );

    instr_mem #(.IMEM_AW(IMEM_AW)) u_imem (
        .clk   (clk),
        .we    (imem_we),
        .addr  (imem_addr),
        .wdata (imem_wdata),
        .rdata (fetched)
    );

    // writeback straight from the execute/writeback register
    reg_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs_sel (rs_sel),
        .rt_sel (rt_sel),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .wr     (xw_pending)
    );

    exec_stage u_exec (
        .clk           (clk),
        .rst_n         (rst_n),
        .freeze        (freeze),
        .issue         (issue),
        .rs_val        (rs_val),
        .rt_val        (rt_val),
        .dx_pending    (dx_pending),
        .xw_pending    (xw_pending),
        .out_fire      (out_fire),
        .host_write_in (host_write_in)
    );

endmodule

// ==== tests/cpu_assertions.sv ====
/*
 * handshake checks on both host links of the cpu
 */
`timescale 1ns/1ns

module cpu_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 load_req,
    input cpu_pkg::load_word_t  load_word,
    input logic                 load_ack,
    input logic                 host_req,
    input cpu_pkg::host_write_t host_write,
    input logic                 host_ack
);
    // payload held while req is up
    load_stable: assert property (@(posedge clk) disable iff (!rst_n)
        load_req && $past(load_req) |-> $stable(load_word)) else $error("load payload changed");
    host_stable: assert property (@(posedge clk) disable iff (!rst_n)
        host_req && $past(host_req) |-> $stable(host_write)) else $error("host payload changed");

    // req only falls after ack
    load_drop: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(load_req) |-> $past(load_ack)) else $error("load_req dropped early");
    host_drop: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(host_req) |-> $past(host_ack)) else $error("host_req dropped early");

    // no new request while the old ack is still up
    load_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(load_req) |-> !$past(load_ack)) else $error("load_req raised too soon");
    host_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(host_req) |-> !$past(host_ack)) else $error("host_req raised too soon");

endmodule

bind cpu_top cpu_assertions u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_req   (load_req),
    .load_word  (load_word),
    .load_ack   (load_ack),
    .host_req   (host_req),
    .host_write (host_write),
    .host_ack   (host_ack)
);

// ==== tests/cpu_tb.sv ====
/*
 * testbench for the cpu that runs the programs of the trace file through
 * the boot link and compares the host writes with the trace
 */
`timescale 1ns/1ns

module cpu_tb;
    import cpu_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        load_req;
    load_word_t  load_word;
    logic        load_ack;
    logic        host_req;
    host_write_t host_write;
    logic        host_ack;
    logic        halted;

    logic [31:0]  trace [0:1023];
    host_write_t  got_writes[$];
    int unsigned  max_delay;
    int           errors;
    int           failed_tests;
    longint       watchdog_ns;
    logic         trace_ready;

    cpu_top #(.IMEM_AW(IMEM_AW_DEFAULT)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_write(host_write_t got, host_write_t exp, int idx);
        if (got !== exp) begin
            $display("Error: t=%0t write %0d got %h/%h, expected %h/%h", $time, idx,
                     got.addr, got.data, exp.addr, exp.data);
            errors++;
        end
    endtask

    task automatic check_halt(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("Error: t=%0t %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic send_word(load_word_t w);
        load_req  <= 1'b1;
        load_word <= w;
        do @(posedge clk); while (!load_ack);
        load_req <= 1'b0;
        do @(posedge clk); while (load_ack);
    endtask

    // host side of the write link with a random ack delay per write
    initial begin
        int unsigned wait_cycles;
        void'($urandom(7724));
        host_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (host_req && !host_ack) begin
                got_writes.push_back(host_write);
                wait_cycles = $urandom % (max_delay + 1);
                repeat (wait_cycles) @(posedge clk);
                host_ack <= 1'b1;
                do @(posedge clk); while (host_req);
                host_ack <= 1'b0;
            end
        end
    end

    initial begin
        wait (trace_ready);
        #(watchdog_ns);
        $display("timeout: the programs did not reach halt in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int ptr;
        int n_tests;
        int n_words;
        int n_writes;
        int errors_before;
        longint total_words;
        host_write_t exp;
        load_word_t w;

        rst_n = 1'b0;
        load_req = 1'b0;
        load_word = '0;
        max_delay = 0;
        errors = 0;
        failed_tests = 0;
        trace_ready = 1'b0;
        $readmemh("tests/program_trace.txt", trace);

        // size the watchdog from the trace before running anything
        n_tests = trace[0];
        ptr = 1;
        total_words = 0;
        for (int t = 0; t < n_tests; t++) begin
            total_words += trace[ptr];
            ptr += 3 + trace[ptr] + 2 * trace[ptr + 2];
        end
        watchdog_ns = (total_words * 200 + n_tests * 20) * 4;
        trace_ready = 1'b1;

        ptr = 1;
        for (int t = 0; t < n_tests; t++) begin
            n_words = trace[ptr];
            max_delay = trace[ptr + 1];
            n_writes = trace[ptr + 2];
            ptr += 3;
            errors_before = errors;

            rst_n <= 1'b0;
            repeat (10) @(posedge clk);
            rst_n <= 1'b1;
            @(posedge clk);
            got_writes.delete();
            check_halt(halted, 1'b0, "halted after reset");
            check_halt(host_req, 1'b0, "host_req after reset");
            check_halt(load_ack, 1'b0, "load_ack after reset");

            for (int i = 0; i < n_words; i++) begin
                w.addr = 8'(i);
                w.data = trace[ptr + i];
                w.last = (i == n_words - 1);
                send_word(w);
            end
            ptr += n_words;

            do @(posedge clk); while (!halted);
            // stays quiet once halted
            repeat (20) begin
                @(posedge clk);
                check_halt(halted, 1'b1, "halted");
                check_halt(host_req, 1'b0, "host_req after halt");
            end

            if (got_writes.size() != n_writes) begin
                $display("Error: t=%0t test %0d saw %0d host writes, expected %0d",
                         $time, t, got_writes.size(), n_writes);
                errors++;
            end
            for (int k = 0; k < n_writes; k++) begin
                exp.addr = trace[ptr + 2 * k][15:0];
                exp.data = trace[ptr + 2 * k + 1];
                if (k < got_writes.size())
                    check_write(got_writes[k], exp, k);
            end
            ptr += 2 * n_writes;

            if (errors == errors_before) begin
                $display("test %0d: passed, %0d writes", t, n_writes);
            end else begin
                $display("test %0d: failed", t);
                failed_tests++;
            end
        end

        $display("tests run %0d, failed %0d, wrong values %0d", n_tests, failed_tests, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tests/program_trace.txt ====
// layout: test count, then per test: word count, max ack delay (cycles), write count,
// then the program words, then one host address and data word per expected write
5
// arithmetic on registers, results sent out by OUT
0d 0 5
10100005 10200003 01312000 02412000 03512000 04612000 05712000
11300100 11400104 11500108 1160010c 11700110 ff000000
0100 00000008  0104 00000002  0108 00000001  010c 00000007  0110 00000006
// negative immediates and OUT address from rs plus immediate
06 3 2
1010ffff 1021fff0 10300200 11130008 1123fffc ff000000
0208 ffffffff  01fc ffffffef
// back-to-back dependent instructions
08 1 2
10100007 01211000 02321000 05432000 11400300 10440001 11400304 ff000000
0300 00000009  0304 0000000a
// same program with no-ops in between, long ack delays
14 28 2
10100007 0 0 01211000 0 0 02321000 0 0 05432000 0 0
11400300 0 0 10440001 0 0 11400304 ff000000
0300 00000009  0304 0000000a
// OUT right after its producer, very long ack delays
05 64 2
10100055 11100010 10110001 11100014 ff000000
0010 00000055  0014 00000056

// ==== tb.f ====
logic/cpu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/instr_mem.sv
logic/exec_stage.sv
logic/cpu_sequencer.sv
logic/cpu_top.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

// ==== Makefile ====
# Verilator simulation of the cpu testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
